//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module spi_mem_tb -f files.f
	@out="$$(./obj_dir/Vspi_mem_tb)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- files.f
verilog/spi_link_pkg.sv
verilog/mem_cmd_pkg.sv
verilog/spi_slave.sv
verilog/byte_fifo.sv
verilog/cmd_executor.sv
verilog/spi_mem_top.sv
test/spi_mem_checker.sv
test/spi_mem_tb.sv

//--- test/spi_mem_checker.sv
`timescale 1ns/1ps

module spi_mem_checker (
  input logic clk,
  input logic arst_n,
  input logic ssel_n,
  input logic miso_en,
  input logic rx_valid,
  input logic overflow
);

  // Output enable mirrors the select line
  a_miso_en : assert property (@(posedge clk) disable iff (!arst_n) miso_en == !ssel_n)
    else $error("miso_en does not follow ssel_n");

  // Byte strobe lasts one cycle
  a_rx_pulse : assert property (@(posedge clk) disable iff (!arst_n) rx_valid |=> !rx_valid)
    else $error("rx_valid high two cycles in a row");

  // Overflow only clears through reset
  a_ovf_sticky : assert property (@(posedge clk) disable iff (!arst_n) overflow |=> overflow)
    else $error("overflow fell without reset");

endmodule

bind spi_mem_top spi_mem_checker u_checker (
  .clk      (clk),
  .arst_n   (arst_n),
  .ssel_n   (ssel_n),
  .miso_en  (miso_en),
  .rx_valid (rx_valid),
  .overflow (overflow)
);

//--- test/spi_mem_stim.txt
# X count mosi_bytes expected_miso_bytes (-- not checked)
# P count bits_in_last_byte mosi_bytes, R register_index expected_value
X 2 10 40 -- --
X 5 20 11 22 33 44 -- -- -- -- --
X 2 10 40 -- --
X 5 30 00 00 00 00 -- 11 22 33 44
X 2 10 fe -- --
X 5 20 a1 a2 a3 a4 -- -- -- -- --
X 2 10 fe -- --
X 5 30 00 00 00 00 -- a1 a2 a3 a4
X 2 40 5a -- --
R 0 5a
R 1 00
R 2 00
R 3 00
X 3 42 c3 77 -- -- --
R 2 c3
R 0 5a
X 2 41 81 -- --
R 1 81
X 2 43 7e -- --
R 3 7e
R 2 c3
X 2 10 40 -- --
P 2 4 10 80
X 3 30 00 00 -- 11 22
X 2 10 41 -- --
X 4 70 99 98 97 -- -- -- --
X 2 10 40 -- --
X 5 30 00 00 00 00 -- 11 22 33 44
R 0 5a
R 1 81

//--- test/spi_mem_tb.sv
`timescale 1ns/1ps

module spi_mem_tb;

  import mem_cmd_pkg::*;

  // clk cycles per SCK phase giving SCK at clk/16
  localparam int HALF_BIT   = 8;
  localparam int MAX_BYTES  = 16;
  // Idle cycles that count as a settled link
  localparam int QUIET_CYC  = 12;
  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       arst_n;
  logic       sck;
  logic       ssel_n;
  logic       mosi;
  logic       miso;
  logic       miso_en;
  ctrl_regs_t ctrl_regs;
  logic       overflow;

  // Bookkeeping
  int fd;
  int n_tests;
  int n_fail;
  int n_err;

  // One message worth of bytes
  logic [7:0]  mosi_q  [MAX_BYTES];
  logic [7:0]  miso_q  [MAX_BYTES];
  logic [63:0] exp_tok [MAX_BYTES];

  spi_mem_top UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck       (sck),
    .ssel_n    (ssel_n),
    .mosi      (mosi),
    .miso      (miso),
    .miso_en   (miso_en),
    .ctrl_regs (ctrl_regs),
    .overflow  (overflow)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////
  // Helpers
  //////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (got_val !== exp_val) begin
      $display("ERR %s exp %0h got %0h", name, exp_val, got_val);
      n_err++;
    end
  endtask

  // Mode 0 bit loop sending MSB first
  // Starts and ends on a falling clk edge
  task automatic shift_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i > 7 - nbits; i--) begin
      sck  = 1'b0;
      mosi = tx[i];
      repeat (HALF_BIT) @(negedge clk);
      // Last moment before the rising edge
      rx[i] = miso;
      sck   = 1'b1;
      repeat (HALF_BIT) @(negedge clk);
    end
  endtask

  // Whole message where the last byte may be cut short
  task automatic send_message(input int nbytes, input int last_bits);
    logic [7:0] rx;
    ssel_n = 1'b0;
    for (int b = 0; b < nbytes; b++) begin
      shift_byte(mosi_q[b], (b == nbytes - 1) ? last_bits : 8, rx);
      miso_q[b] = rx;
    end
    sck    = 1'b0;
    ssel_n = 1'b1;
  endtask

  // Link counts as idle with no strobe and nothing buffered for a while
  task automatic wait_link_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < QUIET_CYC && waited <= WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
      if (UUT.rx_valid || UUT.fifo_not_empty) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < QUIET_CYC) begin
      $display("timeout: link still busy %0d cycles after the message ended", waited);
      n_err++;
    end
  endtask

  task automatic read_mosi(input int n);
    logic [7:0] v;
    int         code;
    for (int b = 0; b < n; b++) begin
      code = $fscanf(fd, "%h", v);
      mosi_q[b] = v;
    end
  endtask

  // Comment lines in the stimulus file
  task automatic skip_line();
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    logic [63:0] kind;
    logic [63:0] tok;
    logic [7:0]  val;
    int          n;
    int          bits;
    int          idx;
    int          code;
    int          errs_before;
    bit          done;

    arst_n  = 1'b0;
    sck     = 1'b0;
    ssel_n  = 1'b1;
    mosi    = 1'b0;
    n_tests = 0;
    n_fail  = 0;
    n_err   = 0;
    done    = 1'b0;

    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);

    // Reset state
    check_value("ctrl_regs", 32'h0, ctrl_regs);
    check_value("overflow", 32'h0, overflow);
    n_tests++;
    if (n_err != 0) begin
      n_fail++;
    end
    $display("case %0d reset %0s", n_tests, (n_err == 0) ? "ok" : "FAILED");

    fd = $fopen("test/spi_mem_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file test/spi_mem_stim.txt");
      n_err++;
      done = 1'b1;
    end

    while (!done && $fscanf(fd, "%s", kind) == 1) begin
      errs_before = n_err;
      if (kind == "#") begin
        skip_line();
      end else begin
        if (kind == "X") begin
          code = $fscanf(fd, "%d", n);
          read_mosi(n);
          for (int b = 0; b < n; b++) begin
            code = $fscanf(fd, "%s", tok);
            exp_tok[b] = tok;
          end
          send_message(n, 8);
          wait_link_idle();
          // Dashes mark a slot nobody cares about
          for (int b = 0; b < n; b++) begin
            if (exp_tok[b] != "--") begin
              code = $sscanf(string'(exp_tok[b]), "%h", val);
              check_value($sformatf("miso byte %0d", b), val, miso_q[b]);
            end
          end
        end else if (kind == "P") begin
          code = $fscanf(fd, "%d %d", n, bits);
          read_mosi(n);
          send_message(n, bits);
          wait_link_idle();
        end else if (kind == "R") begin
          code = $fscanf(fd, "%d %h", idx, val);
          check_value($sformatf("ctrl_regs[%0d]", idx), val, ctrl_regs[idx]);
        end else begin
          $display("unknown test type %0s in the stimulus file", kind);
          n_err++;
          done = 1'b1;
        end
        n_tests++;
        if (n_err != errs_before) begin
          n_fail++;
        end
        $display("case %0d %0s %0s", n_tests, kind, (n_err == errs_before) ? "ok" : "FAILED");
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // Nothing may have been dropped along the way
    check_value("overflow", 32'h0, overflow);

    $display("cases %0d failed %0d errors %0d", n_tests, n_fail, n_err);
    if (n_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wr_en,
  input  spi_link_pkg::link_byte_t wr_data,
  input  logic                     rd_en,
  output spi_link_pkg::link_byte_t rd_data,
  output logic                     not_empty,
  output logic                     overflow
);

  import spi_link_pkg::*;

  // Storage and pointers
  link_byte_t            fifo_mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;

  logic full;
  logic do_wr;
  logic do_rd;

  assign full      = (count == FIFO_DEPTH);
  assign not_empty = (count != '0);

  // Writes into a full buffer are lost
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && not_empty;

  // Show-ahead head
  assign rd_data = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      fifo_mem[wr_ptr] <= wr_data;
    end
  end

  //////////////////////
  // Pointers and level
  //////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset
      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/cmd_executor.sv
`timescale 1ns/1ps

module cmd_executor (
  input  logic                           clk,
  input  logic                           arst_n,
  input  spi_link_pkg::link_byte_t       rd_data,
  input  logic                           not_empty,
  output logic                           rd_en,
  output logic [mem_cmd_pkg::DATA_W-1:0] tx_data,
  output mem_cmd_pkg::ctrl_regs_t        ctrl_regs
);

  import mem_cmd_pkg::*;

  // Byte memory
  logic [DATA_W-1:0] mem [MEM_WORDS];

  // Address counter
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_nxt;

  // Current command
  cmd_word_u        word;
  opcode_e          op_q;
  logic [ARG_W-1:0] arg_q;
  logic             param0_q;

  // Head byte classification and write enables
  logic is_cmd;
  logic is_param;
  logic mem_we;
  logic reg_we;

  // Pop whenever anything is waiting
  assign rd_en = not_empty;

  assign word.raw = rd_data.data;
  assign is_cmd   = rd_en && rd_data.first;
  assign is_param = rd_en && !rd_data.first;

  //////////////////////
  // Parameter decode
  //////////////////////

  always_comb begin
    addr_nxt = addr_q;
    mem_we   = 1'b0;
    reg_we   = 1'b0;
    if (is_param) begin
      case (op_q)
        // Only the first parameter counts
        OP_SET_ADDR: begin
          if (param0_q) begin
            addr_nxt = word.raw[ADDR_W-1:0];
          end
        end
        OP_WRITE: begin
          mem_we   = 1'b1;
          addr_nxt = addr_q + 1'b1;
        end
        // Data already sits on tx_data, just move on
        OP_READ: begin
          addr_nxt = addr_q + 1'b1;
        end
        // Out-of-range register index is dropped
        OP_SET_REG: begin
          reg_we = param0_q && (arg_q < NUM_REGS);
        end
        // Unknown opcode, ignored until next message
        default: begin
          addr_nxt = addr_q;
        end
      endcase
    end
  end

  //////////////////////
  // Control state
  //////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_q    <= '0;
      op_q      <= OP_NOP;
      arg_q     <= '0;
      param0_q  <= 1'b0;
      ctrl_regs <= '0;
    end else begin
      addr_q <= addr_nxt;
      // Command byte restarts the parameter count
      if (is_cmd) begin
        op_q     <= word.cmd.opcode;
        arg_q    <= word.cmd.arg;
        param0_q <= 1'b1;
      end else if (is_param) begin
        param0_q <= 1'b0;
      end
      if (reg_we) begin
        ctrl_regs[arg_q[REG_SEL_W-1:0]] <= word.raw;
      end
    end
  end

  // Memory write and read-ahead of the next address
  // Write goes to addr_q, read to addr_nxt, never the same word
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[addr_q] <= word.raw;
    end
    tx_data <= mem[addr_nxt];
  end

endmodule

//--- verilog/mem_cmd_pkg.sv
package mem_cmd_pkg;

  //////////////////////
  // Memory and registers
  //////////////////////

  // Byte-wide storage
  localparam int DATA_W    = 8;
  localparam int ADDR_W    = 8;
  localparam int MEM_WORDS = 1 << ADDR_W;

  // Control register bank
  localparam int NUM_REGS  = 4;
  localparam int REG_SEL_W = $clog2(NUM_REGS);

  //////////////////////
  // Command byte
  //////////////////////

  // High nibble opcode, low nibble argument
  localparam int OP_W  = 4;
  localparam int ARG_W = DATA_W - OP_W;

  // OP_NOP doubles as the idle state after reset
  typedef enum logic [OP_W-1:0] {
    OP_NOP      = 4'h0,
    OP_SET_ADDR = 4'h1,
    OP_WRITE    = 4'h2,
    OP_READ     = 4'h3,
    OP_SET_REG  = 4'h4
  } opcode_e;

  typedef struct packed {
    opcode_e          opcode;
    logic [ARG_W-1:0] arg;
  } cmd_fields_t;

  // Same byte seen as a command or as a plain parameter
  typedef union packed {
    logic [DATA_W-1:0] raw;
    cmd_fields_t       cmd;
  } cmd_word_u;

  // Register 0 sits in the low byte
  typedef logic [NUM_REGS-1:0][DATA_W-1:0] ctrl_regs_t;

endpackage

//--- verilog/spi_link_pkg.sv
package spi_link_pkg;

  //////////////////////
  // Serial byte link
  //////////////////////

  // Bits per SPI byte, MSB first on the wire
  localparam int BYTE_W = 8;

  // Receive buffer
  // Depth must stay a power of two, pointers wrap on their own
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  //////////////////////
  // Link byte
  //////////////////////

  // One byte as it leaves the slave front end
  // first marks the opening byte after SSEL falls
  typedef struct packed {
    logic [BYTE_W-1:0] data;
    logic              first;
  } link_byte_t;

endpackage

//--- verilog/spi_mem_top.sv
`timescale 1ns/1ps

module spi_mem_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    sck,
  input  logic                    ssel_n,
  input  logic                    mosi,
  output logic                    miso,
  output logic                    miso_en,
  output mem_cmd_pkg::ctrl_regs_t ctrl_regs,
  output logic                    overflow
);

  import spi_link_pkg::*;

  // Slave to FIFO
  link_byte_t rx_byte;
  logic       rx_valid;

  // FIFO to executor
  link_byte_t        fifo_head;
  logic              fifo_not_empty;
  logic              fifo_rd_en;

  // Executor back to the slave
  logic [BYTE_W-1:0] tx_data;

  spi_slave u_spi_slave (
    .clk      (clk),
    .arst_n   (arst_n),
    .sck      (sck),
    .ssel_n   (ssel_n),
    .mosi     (mosi),
    .miso     (miso),
    .miso_en  (miso_en),
    .tx_data  (tx_data),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  byte_fifo u_byte_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (rx_valid),
    .wr_data   (rx_byte),
    .rd_en     (fifo_rd_en),
    .rd_data   (fifo_head),
    .not_empty (fifo_not_empty),
    .overflow  (overflow)
  );

  cmd_executor u_cmd_executor (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_data   (fifo_head),
    .not_empty (fifo_not_empty),
    .rd_en     (fifo_rd_en),
    .tx_data   (tx_data),
    .ctrl_regs (ctrl_regs)
  );

endmodule

//--- verilog/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            sck,
  input  logic                            ssel_n,
  input  logic                            mosi,
  output logic                            miso,
  output logic                            miso_en,
  input  logic [spi_link_pkg::BYTE_W-1:0] tx_data,
  output spi_link_pkg::link_byte_t        rx_byte,
  output logic                            rx_valid
);

  import spi_link_pkg::*;

  // SCK side
  logic                      sck_rst_n;
  logic [$clog2(BYTE_W)-1:0] bit_cnt;
  logic [BYTE_W-1:0]         shift_q;
  logic                      byte_flag;

  // clk side
  logic [1:0] ssel_sync;
  logic       ssel_d;
  logic       msg_start;
  logic [1:0] flag_sync;
  logic       flag_d;
  logic       byte_edge;
  logic       first_pend;

  //////////////////////
  // SCK domain
  //////////////////////

  // Bit counter held clear whenever the slave is deselected
  // so a cut-short byte leaves nothing behind
  assign sck_rst_n = arst_n & ~ssel_n;

  always_ff @(posedge sck or negedge sck_rst_n) begin
    if (!sck_rst_n) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Mode 0, MOSI sampled on the rising edge
  always_ff @(posedge sck) begin
    shift_q <= {shift_q[BYTE_W-2:0], mosi};
  end

  // High for one SCK period after bit 7
  // Not cleared by SSEL, the last byte of a message must survive
  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      byte_flag <= 1'b0;
    end else begin
      byte_flag <= !ssel_n && (bit_cnt == BYTE_W - 1);
    end
  end

  // Transmit byte read live, MSB first
  assign miso    = tx_data[(BYTE_W - 1) - int'(bit_cnt)];
  assign miso_en = ~ssel_n;

  //////////////////////
  // clk domain
  //////////////////////

  // SSEL synchronizer, idles high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ssel_sync <= 2'b11;
      ssel_d    <= 1'b1;
    end else begin
      ssel_sync <= {ssel_sync[0], ssel_n};
      ssel_d    <= ssel_sync[1];
    end
  end

  // Falling SSEL opens a message
  assign msg_start = ssel_d & ~ssel_sync[1];

  // Byte flag: two sync stages, then registered rising-edge detect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flag_sync <= 2'b00;
      flag_d    <= 1'b0;
      byte_edge <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      flag_sync <= {flag_sync[0], byte_flag};
      flag_d    <= flag_sync[1];
      byte_edge <= flag_sync[1] & ~flag_d;
      rx_valid  <= byte_edge;
    end
  end

  // Armed at message start, spent on the first byte
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      first_pend <= 1'b0;
    end else if (msg_start) begin
      first_pend <= 1'b1;
    end else if (byte_edge) begin
      first_pend <= 1'b0;
    end
  end

  // Shift register is quiet here, next SCK edge is many clk cycles away
  always_ff @(posedge clk) begin
    if (byte_edge) begin
      rx_byte.data  <= shift_q;
      rx_byte.first <= first_pend;
    end
  end

endmodule
